//--- common/video_cfg.svh
// Video generator configuration
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// horizontal raster in pixels (visible area first)
`define H_VISIBLE       640
`define H_FRONT         16
`define H_SYNC          96
`define H_BACK          48
`define H_TOTAL         (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical raster in lines
`define V_VISIBLE       480
`define V_FRONT         10
`define V_SYNC          2
`define V_BACK          33
`define V_TOTAL         (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

`define AUDIO_NCHAN     4

`define BORDER_RESET    8'h08           // dark grey, shows the core is alive
`define VSYNC_INTR_BIT  3

// general register numbers
`define XR_VID_CTRL     6'h00
`define XR_AUD_CTRL     6'h02
`define XR_VID_LEFT     6'h04
`define XR_VID_RIGHT    6'h05
`define XR_SCANLINE     6'h08
`define XR_VID_HSIZE    6'h0A
`define XR_VID_VSIZE    6'h0B

// audio channel 0, channel n sits 4*n above
`define XR_AUD0_VOL     6'h20
`define XR_AUD0_PERIOD  6'h21
`define XR_AUD0_LENGTH  6'h22
`define XR_AUD0_START   6'h23

`endif

//--- common/video_pkg.sv
// Video generator types
`default_nettype none

package video_pkg;

typedef logic [15:0] word_t;            // register data word
typedef logic [5:0]  reg_num_t;
typedef logic [9:0]  hres_t;
typedef logic [9:0]  vres_t;
typedef logic [7:0]  color_t;
typedef logic [3:0]  intr_t;

typedef struct packed {
    logic hsync;
    logic vsync;
    logic dv_de;                        // display enable
    logic h_blank;
    logic v_blank;
} vid_sync_t;

// one written word, seen as period or as length
typedef union packed {
    struct packed {
        logic        restart;
        logic [14:0] period;
    } per;
    struct packed {
        logic        tile;              // sample in tile memory
        logic [14:0] length;
    } len;
} aud_reg_word_u;

typedef struct packed {
    logic vol;
    logic period;
    logic length;
    logic start;
} aud_wr_t;

// channel state seen by the mixer
typedef struct packed {
    word_t       vol;                   // L+R volume
    logic [14:0] period;
    logic        tile;
    logic [14:0] length;                // in words
    word_t       start;
    logic        restart;               // one cycle strobe
} aud_chan_t;

endpackage

`default_nettype wire

//--- design/video_timing.sv
// Raster timing generator
`default_nettype none
`timescale 1ns/1ps

`include "video_cfg.svh"

module video_timing (
    input  wire logic               clk,
    input  wire logic               reset_i,
    output video_pkg::hres_t        h_count_o,
    output video_pkg::vres_t        v_count_o,
    output video_pkg::vid_sync_t    sync_o,
    output logic                    end_of_visible_o
);

import video_pkg::*;

localparam hres_t H_VIS        = hres_t'(`H_VISIBLE);
localparam hres_t H_SYNC_START = hres_t'(`H_VISIBLE + `H_FRONT);
localparam hres_t H_SYNC_END   = hres_t'(`H_VISIBLE + `H_FRONT + `H_SYNC);
localparam hres_t H_LAST       = hres_t'(`H_TOTAL - 1);
localparam vres_t V_VIS        = vres_t'(`V_VISIBLE);
localparam vres_t V_SYNC_START = vres_t'(`V_VISIBLE + `V_FRONT);
localparam vres_t V_SYNC_END   = vres_t'(`V_VISIBLE + `V_FRONT + `V_SYNC);
localparam vres_t V_LAST       = vres_t'(`V_TOTAL - 1);

hres_t      h_next;
vres_t      v_next;

// sync, blank and enable for a given raster position
function automatic vid_sync_t sync_of(input hres_t h, input vres_t v);
    vid_sync_t s;
    logic      h_vis;
    logic      v_vis;
    h_vis     = (h < H_VIS);
    v_vis     = (v < V_VIS);
    s.hsync   = (h >= H_SYNC_START) && (h < H_SYNC_END);   // active high pulses
    s.vsync   = (v >= V_SYNC_START) && (v < V_SYNC_END);
    s.dv_de   = h_vis && v_vis;
    s.h_blank = ~h_vis;
    s.v_blank = ~v_vis;
    return s;
endfunction

always_comb begin
    h_next = h_count_o + 1'b1;
    v_next = v_count_o;
    if (h_count_o == H_LAST) begin
        h_next = '0;
        if (v_count_o == V_LAST) begin
            v_next = '0;
        end else begin
            v_next = v_count_o + 1'b1;
        end
    end
end

// sync is computed from the next position so it lines up with the counters
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o        <= '0;
        v_count_o        <= '0;
        sync_o           <= sync_of('0, '0);
        end_of_visible_o <= 1'b0;
    end else begin
        h_count_o        <= h_next;
        v_count_o        <= v_next;
        sync_o           <= sync_of(h_next, v_next);
        // high while the raster sits at the start of the first blank line
        end_of_visible_o <= (h_count_o == H_LAST) && (v_count_o == V_VIS - 1'b1);
    end
end

endmodule

`default_nettype wire

//--- design/video_ctrl_regs.sv
// Video control registers
`default_nettype none
`timescale 1ns/1ps

`include "video_cfg.svh"

module video_ctrl_regs (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           reg_wr_en_i,
    input  wire video_pkg::reg_num_t            reg_num_i,
    input  wire video_pkg::word_t               reg_data_i,
    input  wire logic                           end_of_visible_i,
    output video_pkg::intr_t                    intr_signal_o,
    output video_pkg::color_t                   border_color_o,
    output video_pkg::hres_t                    vid_left_o,
    output video_pkg::hres_t                    vid_right_o,
    output logic [`AUDIO_NCHAN-1:0]             aud_enable_o,
    output video_pkg::aud_wr_t [`AUDIO_NCHAN-1:0] aud_wr_o,
    output video_pkg::word_t                    aud_data_o
);

import video_pkg::*;

// general registers and interrupt pulse
always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_signal_o  <= '0;
        border_color_o <= `BORDER_RESET;
        vid_left_o     <= '0;
        vid_right_o    <= hres_t'(`H_VISIBLE);     // full width visible
        aud_enable_o   <= '0;
    end else begin
        intr_signal_o <= '0;                       // pulses last one cycle

        if (reg_wr_en_i) begin
            case (reg_num_i)
                `XR_VID_CTRL: begin
                    border_color_o <= reg_data_i[15:8];
                    intr_signal_o  <= reg_data_i[3:0];   // software interrupt
                end
                `XR_AUD_CTRL: begin
                    aud_enable_o <= reg_data_i[`AUDIO_NCHAN-1:0];  // read back at bit 8+n
                end
                `XR_VID_LEFT: begin
                    vid_left_o <= reg_data_i[9:0];
                end
                `XR_VID_RIGHT: begin
                    vid_right_o <= reg_data_i[9:0];
                end
                default: begin
                end
            endcase
        end

        if (end_of_visible_i) begin
            intr_signal_o[`VSYNC_INTR_BIT] <= 1'b1;
        end
    end
end

// audio register strobes, one set per channel
always_comb begin
    for (int i = 0; i < `AUDIO_NCHAN; i++) begin
        aud_wr_o[i].vol    = reg_wr_en_i && (reg_num_i == reg_num_t'(`XR_AUD0_VOL + 4 * i));
        aud_wr_o[i].period = reg_wr_en_i && (reg_num_i == reg_num_t'(`XR_AUD0_PERIOD + 4 * i));
        aud_wr_o[i].length = reg_wr_en_i && (reg_num_i == reg_num_t'(`XR_AUD0_LENGTH + 4 * i));
        aud_wr_o[i].start  = reg_wr_en_i && (reg_num_i == reg_num_t'(`XR_AUD0_START + 4 * i));
    end
end

assign aud_data_o = reg_data_i;            // same word goes to every channel

endmodule

`default_nettype wire

//--- design/audio_chan_regs.sv
// Audio channel registers
`default_nettype none
`timescale 1ns/1ps

module audio_chan_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire video_pkg::aud_wr_t     wr_i,
    input  wire video_pkg::word_t       data_i,
    input  wire logic                   reload_i,
    output video_pkg::aud_chan_t        chan_o,
    output logic                        pending_o
);

import video_pkg::*;

aud_reg_word_u  wr_word;
word_t          vol_q;
logic [14:0]    period_q;
logic           tile_q;
logic [14:0]    length_q;
word_t          start_q;
logic           restart_q;

assign wr_word = data_i;

// sample parameters
always_ff @(posedge clk) begin
    if (wr_i.vol) begin
        vol_q <= data_i;
    end
    if (wr_i.period) begin
        period_q <= wr_word.per.period;
    end
    if (wr_i.length) begin
        tile_q   <= wr_word.len.tile;
        length_q <= wr_word.len.length;
    end
    if (wr_i.start) begin
        start_q <= data_i;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        restart_q <= 1'b0;
        pending_o <= 1'b0;
    end else begin
        restart_q <= wr_i.period && wr_word.per.restart;
        if (wr_i.start) begin
            pending_o <= 1'b1;                 // new start wins over a reload
        end else if (reload_i) begin
            pending_o <= 1'b0;                 // mixer took start/length
        end
    end
end

assign chan_o = '{
    vol:     vol_q,
    period:  period_q,
    tile:    tile_q,
    length:  length_q,
    start:   start_q,
    restart: restart_q
};

endmodule

`default_nettype wire

//--- design/video_reg_readback.sv
// Register readback mux
`default_nettype none
`timescale 1ns/1ps

`include "video_cfg.svh"

module video_reg_readback (
    input  wire logic                       clk,
    input  wire video_pkg::reg_num_t        reg_num_i,
    input  wire video_pkg::color_t          border_color_i,
    input  wire video_pkg::hres_t           vid_left_i,
    input  wire video_pkg::hres_t           vid_right_i,
    input  wire logic [`AUDIO_NCHAN-1:0]    aud_enable_i,
    input  wire logic [`AUDIO_NCHAN-1:0]    aud_pending_i,
    input  wire video_pkg::vres_t           v_count_i,
    output video_pkg::word_t                reg_data_o
);

import video_pkg::*;

word_t  rd_data;

always_comb begin
    rd_data = '0;
    case (reg_num_i)
        `XR_VID_CTRL: begin
            rd_data = {border_color_i, 8'h00};
        end
        `XR_AUD_CTRL: begin
            rd_data[8 +: `AUDIO_NCHAN] = aud_enable_i;
            rd_data[0 +: `AUDIO_NCHAN] = aud_pending_i;
        end
        `XR_VID_LEFT:  rd_data = word_t'(vid_left_i);
        `XR_VID_RIGHT: rd_data = word_t'(vid_right_i);
        `XR_SCANLINE:  rd_data = word_t'(v_count_i);
        `XR_VID_HSIZE: rd_data = word_t'(`H_VISIBLE);
        `XR_VID_VSIZE: rd_data = word_t'(`V_VISIBLE);
        default: begin
            rd_data = '0;                      // unused and write-only registers
        end
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_data;
end

endmodule

`default_nettype wire

//--- design/video_gen.sv
// Video generator top
`default_nettype none
`timescale 1ns/1ps

`include "video_cfg.svh"

module video_gen (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               reg_wr_en_i,
    input  wire video_pkg::reg_num_t                reg_num_i,
    input  wire video_pkg::word_t                   reg_data_i,
    input  wire logic [`AUDIO_NCHAN-1:0]            aud_reload_i,   // from mixer
    output video_pkg::word_t                        reg_data_o,
    output video_pkg::intr_t                        intr_signal_o,
    output video_pkg::vid_sync_t                    vid_sync_o,
    output video_pkg::aud_chan_t [`AUDIO_NCHAN-1:0] aud_chan_o
);

import video_pkg::*;

vres_t                      v_count;
logic                       end_of_visible;
color_t                     border_color;
hres_t                      vid_left;
hres_t                      vid_right;
logic [`AUDIO_NCHAN-1:0]    aud_enable;
logic [`AUDIO_NCHAN-1:0]    aud_pending;
aud_wr_t [`AUDIO_NCHAN-1:0] aud_wr;
word_t                      aud_data;

video_timing u_timing (
    .clk              (clk),
    .reset_i          (reset_i),
    .h_count_o        (),
    .v_count_o        (v_count),
    .sync_o           (vid_sync_o),
    .end_of_visible_o (end_of_visible)
);

video_ctrl_regs u_ctrl (
    .clk              (clk),
    .reset_i          (reset_i),
    .reg_wr_en_i      (reg_wr_en_i),
    .reg_num_i        (reg_num_i),
    .reg_data_i       (reg_data_i),
    .end_of_visible_i (end_of_visible),
    .intr_signal_o    (intr_signal_o),
    .border_color_o   (border_color),
    .vid_left_o       (vid_left),
    .vid_right_o      (vid_right),
    .aud_enable_o     (aud_enable),
    .aud_wr_o         (aud_wr),
    .aud_data_o       (aud_data)
);

for (genvar i = 0; i < `AUDIO_NCHAN; i++) begin : g_chan
    audio_chan_regs u_chan (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_i      (aud_wr[i]),
        .data_i    (aud_data),
        .reload_i  (aud_reload_i[i]),
        .chan_o    (aud_chan_o[i]),
        .pending_o (aud_pending[i])
    );
end

video_reg_readback u_readback (
    .clk            (clk),
    .reg_num_i      (reg_num_i),
    .border_color_i (border_color),
    .vid_left_i     (vid_left),
    .vid_right_i    (vid_right),
    .aud_enable_i   (aud_enable),
    .aud_pending_i  (aud_pending),
    .v_count_i      (v_count),
    .reg_data_o     (reg_data_o)
);

endmodule

`default_nettype wire

//--- dv/video_gen_tb.sv
// Video generator testbench
`default_nettype none
`timescale 1ns/1ps

`include "video_cfg.svh"

module video_gen_tb;

import video_pkg::*;

localparam int unsigned FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
localparam int unsigned TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 2000;

logic                           clk;
logic                           reset_i;
logic                           reg_wr_en_i;
reg_num_t                       reg_num_i;
word_t                          reg_data_i;
logic [`AUDIO_NCHAN-1:0]        aud_reload_i;
word_t                          reg_data_o;
intr_t                          intr_signal_o;
vid_sync_t                      vid_sync_o;
aud_chan_t [`AUDIO_NCHAN-1:0]   aud_chan_o;

// register model, updated on the clock edge that takes a write
color_t                         exp_border;
hres_t                          exp_left;
hres_t                          exp_right;
logic [`AUDIO_NCHAN-1:0]        exp_enable;
logic [`AUDIO_NCHAN-1:0]        exp_pending;
logic [`AUDIO_NCHAN-1:0]        exp_restart;
intr_t                          exp_intr;
word_t                          exp_vol [`AUDIO_NCHAN];
logic [14:0]                    exp_period [`AUDIO_NCHAN];
logic                           exp_tile [`AUDIO_NCHAN];
logic [14:0]                    exp_length [`AUDIO_NCHAN];
word_t                          exp_start [`AUDIO_NCHAN];

word_t                          rd_expect;
logic                           rd_armed;
logic                           rd_enable;
logic                           intr_enable;
logic                           chan_enable;
int unsigned                    cycle_count = 0;

video_gen i_video_gen (
    .clk           (clk),
    .reset_i       (reset_i),
    .reg_wr_en_i   (reg_wr_en_i),
    .reg_num_i     (reg_num_i),
    .reg_data_i    (reg_data_i),
    .aud_reload_i  (aud_reload_i),
    .reg_data_o    (reg_data_o),
    .intr_signal_o (intr_signal_o),
    .vid_sync_o    (vid_sync_o),
    .aud_chan_o    (aud_chan_o)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

task automatic check_value(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
        $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
        $display("TB FAILED");
        $fatal(1, "value mismatch");
    end
endtask

// register map as seen from the bus
task automatic apply_write(input reg_num_t num, input word_t data);
    int n;
    int ch;
    n  = int'(num);
    ch = (n - int'(`XR_AUD0_VOL)) / 4;
    case (num)
        `XR_VID_CTRL: begin
            exp_border = data[15:8];
            exp_intr   = data[3:0];
        end
        `XR_AUD_CTRL:  exp_enable = data[`AUDIO_NCHAN-1:0];
        `XR_VID_LEFT:  exp_left = data[9:0];
        `XR_VID_RIGHT: exp_right = data[9:0];
        default: begin
        end
    endcase
    if (n >= int'(`XR_AUD0_VOL) && n < int'(`XR_AUD0_VOL) + 4 * `AUDIO_NCHAN) begin
        case (n % 4)
            0: exp_vol[ch] = data;
            1: begin
                exp_period[ch]  = data[14:0];
                exp_restart[ch] = data[15];         // one cycle strobe
            end
            2: begin
                exp_tile[ch]   = data[15];
                exp_length[ch] = data[14:0];
            end
            default: begin
                exp_start[ch]   = data;
                exp_pending[ch] = 1'b1;
            end
        endcase
    end
endtask

function automatic word_t expected_read(input reg_num_t num);
    word_t w;
    w = '0;
    case (num)
        `XR_VID_CTRL:  w = {exp_border, 8'h00};
        `XR_AUD_CTRL: begin
            w[8 +: `AUDIO_NCHAN] = exp_enable;
            w[0 +: `AUDIO_NCHAN] = exp_pending;
        end
        `XR_VID_LEFT:  w = word_t'(exp_left);
        `XR_VID_RIGHT: w = word_t'(exp_right);
        `XR_VID_HSIZE: w = word_t'(`H_VISIBLE);
        `XR_VID_VSIZE: w = word_t'(`V_VISIBLE);
        default:       w = '0;
    endcase
    return w;
endfunction

function automatic aud_chan_t expected_chan(input int ch);
    aud_chan_t c;
    c.vol     = exp_vol[ch];
    c.period  = exp_period[ch];
    c.tile    = exp_tile[ch];
    c.length  = exp_length[ch];
    c.start   = exp_start[ch];
    c.restart = exp_restart[ch];
    return c;
endfunction

always @(posedge clk) begin
    if (reset_i) begin
        exp_border  = `BORDER_RESET;
        exp_left    = '0;
        exp_right   = hres_t'(`H_VISIBLE);
        exp_enable  = '0;
        exp_pending = '0;
        exp_restart = '0;
        exp_intr    = '0;
    end else begin
        exp_intr    = '0;
        exp_restart = '0;
        exp_pending = exp_pending & ~aud_reload_i;      // a start write below wins
        if (reg_wr_en_i) begin
            apply_write(reg_num_i, reg_data_i);
        end
    end
end

// outputs are settled half a cycle after the edge
always @(negedge clk) begin
    if (rd_armed) begin
        check_value(64'(reg_data_o), 64'(rd_expect), "register read");
    end
    rd_expect = expected_read(reg_num_i);
    rd_armed  = rd_enable;
    if (intr_enable) begin
        check_value(64'(intr_signal_o), 64'(exp_intr), "interrupt");
    end
    if (chan_enable) begin
        for (int ch = 0; ch < `AUDIO_NCHAN; ch++) begin
            check_value(64'(aud_chan_o[ch]), 64'(expected_chan(ch)), "audio channel");
        end
    end
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end
end

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic write_reg(input reg_num_t num, input word_t data);
    reg_wr_en_i = 1'b1;
    reg_num_i   = num;
    reg_data_i  = data;
    next_cycle();
    reg_wr_en_i = 1'b0;
endtask

task automatic read_reg(input reg_num_t num, output word_t data);
    reg_num_i = num;
    next_cycle();
    @(negedge clk);
    data = reg_data_o;
    next_cycle();
endtask

// hsync spacing, display enable per line, sync and blank widths over one frame
task automatic check_raster();
    int unsigned t;
    int unsigned t_hs;
    int unsigned de_run;
    int unsigned lines;
    int unsigned hs_cycles;
    int unsigned hb_cycles;
    int unsigned vs_cycles;
    int unsigned vb_cycles;
    logic        hs_prev;
    logic        hs_seen;
    reg_num_i = `XR_SCANLINE;
    @(negedge clk);
    while (!intr_signal_o[`VSYNC_INTR_BIT]) @(negedge clk);
    check_value(64'(reg_data_o), 64'(`V_VISIBLE), "scanline at vsync interrupt");
    t         = 0;
    t_hs      = 0;
    de_run    = 0;
    lines     = 0;
    hs_cycles = 0;
    hb_cycles = 0;
    vs_cycles = 0;
    vb_cycles = 0;
    hs_seen   = 1'b0;
    hs_prev   = vid_sync_o.hsync;
    do begin
        @(negedge clk);
        t++;
        if (vid_sync_o.dv_de) de_run++;
        if (vid_sync_o.hsync) hs_cycles++;
        if (vid_sync_o.h_blank) hb_cycles++;
        if (vid_sync_o.vsync) vs_cycles++;
        if (vid_sync_o.v_blank) vb_cycles++;
        check_value(64'(vid_sync_o.dv_de),
                    64'(!vid_sync_o.h_blank && !vid_sync_o.v_blank),
                    "display enable against blank flags");
        if (vid_sync_o.hsync && !hs_prev) begin
            if (hs_seen) check_value(64'(t - t_hs), 64'(`H_TOTAL), "hsync period");
            if (de_run != 0) begin
                check_value(64'(de_run), 64'(`H_VISIBLE), "display enable per line");
                lines++;
            end
            hs_seen = 1'b1;
            t_hs    = t;
            de_run  = 0;
        end
        hs_prev = vid_sync_o.hsync;
    end while (!intr_signal_o[`VSYNC_INTR_BIT]);
    check_value(64'(t), 64'(FRAME_CYCLES), "vsync interrupt period");
    check_value(64'(lines), 64'(`V_VISIBLE), "visible lines per frame");
    check_value(64'(hs_cycles), 64'(`H_SYNC * `V_TOTAL), "hsync cycles per frame");
    check_value(64'(hb_cycles), 64'((`H_TOTAL - `H_VISIBLE) * `V_TOTAL),
                "hblank cycles per frame");
    check_value(64'(vs_cycles), 64'(`V_SYNC * `H_TOTAL), "vsync cycles per frame");
    check_value(64'(vb_cycles), 64'((`V_TOTAL - `V_VISIBLE) * `H_TOTAL),
                "vblank cycles per frame");
    check_value(64'(reg_data_o), 64'(`V_VISIBLE), "scanline at vsync interrupt");
endtask

initial begin
    word_t    rd;
    word_t    wdata;
    reg_num_t num;
    reset_i      = 1'b1;
    reg_wr_en_i  = 1'b0;
    reg_num_i    = '0;
    reg_data_i   = '0;
    aud_reload_i = '0;
    rd_enable    = 1'b0;
    rd_armed     = 1'b0;
    intr_enable  = 1'b0;
    chan_enable  = 1'b0;
    void'($urandom(32'h0c65_ca58));
    repeat (16) @(posedge clk);
    #1;
    reset_i     = 1'b0;
    rd_enable   = 1'b1;
    intr_enable = 1'b1;

    read_reg(`XR_VID_CTRL, rd);
    read_reg(`XR_VID_RIGHT, rd);
    read_reg(`XR_VID_LEFT, rd);
    read_reg(`XR_VID_HSIZE, rd);
    read_reg(`XR_VID_VSIZE, rd);
    read_reg(`XR_AUD_CTRL, rd);
    for (int ch = 0; ch < `AUDIO_NCHAN; ch++) begin
        check_value(64'(aud_chan_o[ch].restart), 64'(0), "restart after reset");
    end

    repeat (40) begin
        case ($urandom % 5)
            0:       num = `XR_VID_CTRL;
            1:       num = `XR_VID_LEFT;
            2:       num = `XR_VID_RIGHT;
            3:       num = `XR_AUD_CTRL;
            default: num = reg_num_t'(16 + $urandom % 16);     // unused block
        endcase
        write_reg(num, 16'($urandom));
        read_reg(num, rd);
    end

    repeat (4) begin
        wdata = 16'($urandom) | 16'h0001;
        write_reg(`XR_VID_CTRL, wdata);
        @(negedge clk);
        check_value(64'(intr_signal_o), 64'(wdata[3:0]), "software interrupt");
        next_cycle();
        @(negedge clk);
        check_value(64'(intr_signal_o), 64'(0), "software interrupt end");
        next_cycle();
    end

    for (int ch = 0; ch < `AUDIO_NCHAN; ch++) begin
        write_reg(reg_num_t'(`XR_AUD0_VOL + 4 * ch), 16'($urandom));
        write_reg(reg_num_t'(`XR_AUD0_PERIOD + 4 * ch), 16'($urandom) & 16'h7fff);
        write_reg(reg_num_t'(`XR_AUD0_LENGTH + 4 * ch), 16'($urandom));
        write_reg(reg_num_t'(`XR_AUD0_START + 4 * ch), 16'($urandom));
    end
    chan_enable = 1'b1;
    repeat (48) begin
        write_reg(reg_num_t'(`XR_AUD0_VOL + $urandom % (4 * `AUDIO_NCHAN)), 16'($urandom));
    end

    for (int ch = 0; ch < `AUDIO_NCHAN; ch++) begin
        write_reg(reg_num_t'(`XR_AUD0_PERIOD + 4 * ch), 16'($urandom) | 16'h8000);
        @(negedge clk);
        check_value(64'(aud_chan_o[ch].restart), 64'(1), "restart pulse");
        next_cycle();
        @(negedge clk);
        check_value(64'(aud_chan_o[ch].restart), 64'(0), "restart pulse end");
        next_cycle();

        write_reg(reg_num_t'(`XR_AUD0_START + 4 * ch), 16'($urandom));
        read_reg(`XR_AUD_CTRL, rd);
        check_value(64'(rd[ch]), 64'(1), "pending after start write");
        aud_reload_i[ch] = 1'b1;
        next_cycle();
        aud_reload_i[ch] = 1'b0;
        read_reg(`XR_AUD_CTRL, rd);
        check_value(64'(rd[ch]), 64'(0), "pending after reload");
        aud_reload_i[ch] = 1'b1;                               // reload meets a start write
        write_reg(reg_num_t'(`XR_AUD0_START + 4 * ch), 16'($urandom));
        aud_reload_i[ch] = 1'b0;
        read_reg(`XR_AUD_CTRL, rd);
        check_value(64'(rd[ch]), 64'(1), "pending when reload meets start write");
    end

    rd_enable   = 1'b0;
    intr_enable = 1'b0;
    check_raster();

    $display("TB PASSED");
    $finish;
end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/video_pkg.sv
design/video_timing.sv
design/video_ctrl_regs.sv
design/audio_chan_regs.sv
design/video_reg_readback.sv
design/video_gen.sv
dv/video_gen_tb.sv

//--- build.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, a failing run exits non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module video_gen_tb \
    -f build.f \
    -o video_gen_tb

./obj_dir/video_gen_tb
